//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  localparam logic [2:0] FUNCT3_ADD    = 3'b000;
  localparam logic [2:0] FUNCT3_SUB    = 3'b000;
  localparam logic [2:0] FUNCT3_XOR    = 3'b100;
  localparam logic [2:0] FUNCT3_OR     = 3'b110;
  localparam logic [2:0] FUNCT3_SLTU   = 3'b011;
  localparam logic [2:0] FUNCT3_ADDI   = 3'b000;
  localparam logic [2:0] FUNCT3_SLTIU  = 3'b011;
  localparam logic [2:0] FUNCT3_BEQ    = 3'b000;
  localparam logic [2:0] FUNCT3_BNE    = 3'b001;
  localparam logic [2:0] FUNCT3_BLT    = 3'b100;
  localparam logic [2:0] FUNCT3_BGE    = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU   = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU   = 3'b111;
  localparam logic [2:0] FUNCT3_JALR   = 3'b000;
  localparam logic [2:0] FUNCT3_EBREAK = 3'b000;

  localparam logic [6:0]  FUNCT7_BASE    = 7'b0000000;
  localparam logic [6:0]  FUNCT7_SUB     = 7'b0100000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

  typedef enum logic [2:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_SLTU, ALU_LINK
  } alu_op_e;

  typedef enum logic [3:0] {
    TRAN_NOP, TRAN_BEQ, TRAN_BNE, TRAN_BLT, TRAN_BGE,
    TRAN_BLTU, TRAN_BGEU, TRAN_JAL, TRAN_JALR
  } tran_op_e;

endpackage

//--- rtl/inst_fifo.sv
`timescale 1ns/100ps

module inst_fifo
  import rv_core_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            push_valid_i,
  input  logic            pop_ready_i,
  input  logic [XLEN-1:0] push_pc_i,
  input  logic [XLEN-1:0] push_inst_i,
  output logic            push_ready_o,
  output logic            pop_valid_o,
  output logic [XLEN-1:0] pop_pc_o,
  output logic [XLEN-1:0] pop_inst_o
);

  logic [XLEN-1:0]       pc_mem   [FIFO_DEPTH];
  logic [XLEN-1:0]       inst_mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;

  assign push_ready_o = (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign pop_valid_o  = (count != '0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  assign pop_pc_o   = pc_mem[rd_ptr];
  assign pop_inst_o = inst_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_mem[wr_ptr]   <= push_pc_i;
      inst_mem[wr_ptr] <= push_inst_i;
    end
  end

  // Depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/inst_decode.sv
`timescale 1ns/100ps

module inst_decode
  import rv_core_pkg::*;
(
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       inst_i,
  input  logic [XLEN-1:0]       data1_i,
  input  logic [XLEN-1:0]       data2_i,
  output logic [REG_ADDR_W-1:0] raddr1_o,
  output logic [REG_ADDR_W-1:0] raddr2_o,
  output logic [REG_ADDR_W-1:0] waddr_o,
  output logic                  wena_o,
  output logic                  illegal_o,
  output logic                  ebreak_o,
  output alu_op_e               alu_op_o,
  output tran_op_e              tran_op_o,
  output logic [XLEN-1:0]       operand1_o,
  output logic [XLEN-1:0]       operand2_o,
  output logic [XLEN-1:0]       imm_o,
  output logic [XLEN-1:0]       pc_o
);

  logic [11:0]           funct12;
  logic [6:0]            funct7;
  logic [2:0]            funct3;
  logic [6:0]            opcode;
  logic [REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]       imm_i_type, imm_u_type, imm_b_type, imm_j_type;
  logic inst_add, inst_sub, inst_xor, inst_or, inst_sltu, inst_sltiu, inst_addi;
  logic inst_lui, inst_auipc, inst_beq, inst_bne, inst_blt, inst_bge;
  logic inst_bltu, inst_bgeu, inst_jal, inst_jalr, inst_ebreak;
  logic is_rtype, is_branch, rena1, rena2;

  assign funct12 = inst_i[31:20];
  assign funct7  = inst_i[31:25];
  assign rs2     = inst_i[24:20];
  assign rs1     = inst_i[19:15];
  assign funct3  = inst_i[14:12];
  assign rd      = inst_i[11:7];
  assign opcode  = inst_i[6:0];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // Integer compute
  assign inst_add   = (opcode == OPCODE_OP) & (funct3 == FUNCT3_ADD) & (funct7 == FUNCT7_BASE);
  assign inst_sub   = (opcode == OPCODE_OP) & (funct3 == FUNCT3_SUB) & (funct7 == FUNCT7_SUB);
  assign inst_xor   = (opcode == OPCODE_OP) & (funct3 == FUNCT3_XOR) & (funct7 == FUNCT7_BASE);
  assign inst_or    = (opcode == OPCODE_OP) & (funct3 == FUNCT3_OR) & (funct7 == FUNCT7_BASE);
  assign inst_sltu  = (opcode == OPCODE_OP) & (funct3 == FUNCT3_SLTU) & (funct7 == FUNCT7_BASE);
  assign inst_sltiu = (opcode == OPCODE_OP_IMM) & (funct3 == FUNCT3_SLTIU);
  assign inst_addi  = (opcode == OPCODE_OP_IMM) & (funct3 == FUNCT3_ADDI);
  assign inst_lui   = (opcode == OPCODE_LUI);
  assign inst_auipc = (opcode == OPCODE_AUIPC);

  // Control transfer
  assign inst_beq  = (opcode == OPCODE_BRANCH) & (funct3 == FUNCT3_BEQ);
  assign inst_bne  = (opcode == OPCODE_BRANCH) & (funct3 == FUNCT3_BNE);
  assign inst_blt  = (opcode == OPCODE_BRANCH) & (funct3 == FUNCT3_BLT);
  assign inst_bge  = (opcode == OPCODE_BRANCH) & (funct3 == FUNCT3_BGE);
  assign inst_bltu = (opcode == OPCODE_BRANCH) & (funct3 == FUNCT3_BLTU);
  assign inst_bgeu = (opcode == OPCODE_BRANCH) & (funct3 == FUNCT3_BGEU);
  assign inst_jal  = (opcode == OPCODE_JAL);
  assign inst_jalr = (opcode == OPCODE_JALR) & (funct3 == FUNCT3_JALR);

  assign inst_ebreak = (opcode == OPCODE_SYSTEM) & (funct3 == FUNCT3_EBREAK) &
                       (funct12 == FUNCT12_EBREAK);

  assign is_rtype  = inst_add | inst_sub | inst_xor | inst_or | inst_sltu;
  assign is_branch = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

  // Loads, stores and everything else land here
  assign illegal_o = ~(is_rtype | is_branch | inst_sltiu | inst_addi | inst_lui |
                       inst_auipc | inst_jal | inst_jalr | inst_ebreak);
  assign ebreak_o  = inst_ebreak;

  assign rena1  = is_rtype | is_branch | inst_sltiu | inst_addi | inst_jalr;
  assign rena2  = is_rtype | is_branch;
  assign wena_o = is_rtype | inst_sltiu | inst_addi | inst_lui | inst_auipc |
                  inst_jal | inst_jalr;

  assign raddr1_o = rena1 ? rs1 : '0;
  assign raddr2_o = rena2 ? rs2 : '0;
  assign waddr_o  = wena_o ? rd : '0;

  assign imm_o = (inst_addi | inst_sltiu | inst_jalr) ? imm_i_type :
                 (inst_lui | inst_auipc)              ? imm_u_type :
                 (is_branch)                          ? imm_b_type :
                 (inst_jal)                           ? imm_j_type : '0;

  assign alu_op_o = (inst_add | inst_addi | inst_lui | inst_auipc) ? ALU_ADD  :
                    (inst_sub)                                     ? ALU_SUB  :
                    (inst_xor)                                     ? ALU_XOR  :
                    (inst_or)                                      ? ALU_OR   :
                    (inst_sltu | inst_sltiu)                       ? ALU_SLTU :
                    (inst_jal | inst_jalr)                         ? ALU_LINK : ALU_NOP;

  assign operand1_o = (rena1)      ? data1_i :
                      (inst_auipc) ? pc_i    : '0;

  // Jumps carry the pc for the link value
  assign operand2_o = (rena2)                                           ? data2_i :
                      (inst_addi | inst_sltiu | inst_lui | inst_auipc)  ? imm_o   :
                      (inst_jal | inst_jalr)                            ? pc_i    : '0;

  assign tran_op_o = (inst_beq)  ? TRAN_BEQ  :
                     (inst_bne)  ? TRAN_BNE  :
                     (inst_blt)  ? TRAN_BLT  :
                     (inst_bge)  ? TRAN_BGE  :
                     (inst_bltu) ? TRAN_BLTU :
                     (inst_bgeu) ? TRAN_BGEU :
                     (inst_jal)  ? TRAN_JAL  :
                     (inst_jalr) ? TRAN_JALR : TRAN_NOP;

  assign pc_o = pc_i;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/100ps

module regfile
  import rv_core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit
  import rv_core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  head_valid_i,
  input  logic                  res_ready_i,
  input  logic                  wena_i,
  input  logic                  illegal_i,
  input  logic                  ebreak_i,
  input  alu_op_e               alu_op_i,
  input  tran_op_e              tran_op_i,
  input  logic [XLEN-1:0]       operand1_i,
  input  logic [XLEN-1:0]       operand2_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  output logic                  head_ready_o,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  res_valid_o,
  output logic [XLEN-1:0]       res_pc_o,
  output logic [REG_ADDR_W-1:0] res_rd_o,
  output logic                  res_wena_o,
  output logic [XLEN-1:0]       res_wdata_o,
  output logic                  res_taken_o,
  output logic [XLEN-1:0]       res_target_o,
  output logic                  res_illegal_o,
  output logic                  res_ebreak_o
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] target;
  logic            taken;
  logic            eq, lt_s, lt_u;
  logic            fire;
  logic            wena;

  assign eq   = (operand1_i == operand2_i);
  assign lt_s = ($signed(operand1_i) < $signed(operand2_i));
  assign lt_u = (operand1_i < operand2_i);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_result = operand1_i + operand2_i;
      ALU_SUB:  alu_result = operand1_i - operand2_i;
      ALU_XOR:  alu_result = operand1_i ^ operand2_i;
      ALU_OR:   alu_result = operand1_i | operand2_i;
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_LINK: alu_result = operand2_i + XLEN'(4);
      default:  alu_result = '0;
    endcase
  end

  always_comb begin
    case (tran_op_i)
      TRAN_BEQ:  taken = eq;
      TRAN_BNE:  taken = ~eq;
      TRAN_BLT:  taken = lt_s;
      TRAN_BGE:  taken = ~lt_s;
      TRAN_BLTU: taken = lt_u;
      TRAN_BGEU: taken = ~lt_u;
      TRAN_JAL:  taken = 1'b1;
      TRAN_JALR: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
    // Target only reported when the transfer happens
    if (!taken) begin
      target = '0;
    end else if (tran_op_i == TRAN_JALR) begin
      target = (operand1_i + imm_i) & ~XLEN'(1);
    end else begin
      target = pc_i + imm_i;
    end
  end

  // Output slot free or draining this cycle
  assign head_ready_o = ~res_valid_o | res_ready_i;
  assign fire         = head_valid_i & head_ready_o;
  assign wena         = wena_i & ~illegal_i;

  assign rf_we_o    = fire & wena;
  assign rf_waddr_o = waddr_i;
  assign rf_wdata_o = alu_result;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_o <= 1'b0;
    end else if (head_ready_o) begin
      res_valid_o <= head_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      res_pc_o      <= pc_i;
      res_rd_o      <= waddr_i;
      res_wena_o    <= wena;
      res_wdata_o   <= alu_result;
      res_taken_o   <= taken;
      res_target_o  <= target;
      res_illegal_o <= illegal_i;
      res_ebreak_o  <= ebreak_i;
    end
  end

endmodule

//--- rtl/rv_exec_top.sv
`timescale 1ns/100ps

module rv_exec_top
  import rv_core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [XLEN-1:0]       in_pc_i,
  input  logic [XLEN-1:0]       in_inst_i,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [XLEN-1:0]       res_pc_o,
  output logic [REG_ADDR_W-1:0] res_rd_o,
  output logic                  res_wena_o,
  output logic [XLEN-1:0]       res_wdata_o,
  output logic                  res_taken_o,
  output logic [XLEN-1:0]       res_target_o,
  output logic                  res_illegal_o,
  output logic                  res_ebreak_o
);

  logic                  head_valid, head_ready;
  logic [XLEN-1:0]       head_pc, head_inst;
  logic [REG_ADDR_W-1:0] raddr1, raddr2, waddr;
  logic [XLEN-1:0]       rdata1, rdata2;
  logic                  wena, illegal, ebreak;
  alu_op_e               alu_op;
  tran_op_e              tran_op;
  logic [XLEN-1:0]       operand1, operand2, imm, pc;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  inst_fifo i_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_valid_i (in_valid_i),
    .pop_ready_i  (head_ready),
    .push_pc_i    (in_pc_i),
    .push_inst_i  (in_inst_i),
    .push_ready_o (in_ready_o),
    .pop_valid_o  (head_valid),
    .pop_pc_o     (head_pc),
    .pop_inst_o   (head_inst)
  );

  inst_decode i_decode (
    .pc_i       (head_pc),
    .inst_i     (head_inst),
    .data1_i    (rdata1),
    .data2_i    (rdata2),
    .raddr1_o   (raddr1),
    .raddr2_o   (raddr2),
    .waddr_o    (waddr),
    .wena_o     (wena),
    .illegal_o  (illegal),
    .ebreak_o   (ebreak),
    .alu_op_o   (alu_op),
    .tran_op_o  (tran_op),
    .operand1_o (operand1),
    .operand2_o (operand2),
    .imm_o      (imm),
    .pc_o       (pc)
  );

  regfile i_regfile (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .we_i     (rf_we),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  exec_unit i_exec (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .head_valid_i  (head_valid),
    .res_ready_i   (res_ready_i),
    .wena_i        (wena),
    .illegal_i     (illegal),
    .ebreak_i      (ebreak),
    .alu_op_i      (alu_op),
    .tran_op_i     (tran_op),
    .operand1_i    (operand1),
    .operand2_i    (operand2),
    .imm_i         (imm),
    .pc_i          (pc),
    .waddr_i       (waddr),
    .head_ready_o  (head_ready),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .res_valid_o   (res_valid_o),
    .res_pc_o      (res_pc_o),
    .res_rd_o      (res_rd_o),
    .res_wena_o    (res_wena_o),
    .res_wdata_o   (res_wdata_o),
    .res_taken_o   (res_taken_o),
    .res_target_o  (res_target_o),
    .res_illegal_o (res_illegal_o),
    .res_ebreak_o  (res_ebreak_o)
  );

endmodule

//--- include/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// Each row holds name, pc, instruction, rd, wena, wdata, taken, target, illegal, ebreak
function automatic void build_case_table();
  // Register setup
  add_case("addi_x1",      'h100, 'h07b00093, 1,  1, 'h0000007b, 0, 'h0,   0, 0);
  add_case("addi_neg",     'h104, 'hfff00113, 2,  1, 'hffffffff, 0, 'h0,   0, 0);
  add_case("lui_x3",       'h108, 'h123451b7, 3,  1, 'h12345000, 0, 'h0,   0, 0);
  add_case("auipc_x4",     'h10c, 'h00001217, 4,  1, 'h0000110c, 0, 'h0,   0, 0);
  // Results chained through the register file
  add_case("add_x5",       'h110, 'h003082b3, 5,  1, 'h1234507b, 0, 'h0,   0, 0);
  add_case("sub_x6",       'h114, 'h40128333, 6,  1, 'h12345000, 0, 'h0,   0, 0);
  add_case("xor_x7",       'h118, 'h003143b3, 7,  1, 'hedcbafff, 0, 'h0,   0, 0);
  add_case("or_x8",        'h11c, 'h0040e433, 8,  1, 'h0000117f, 0, 'h0,   0, 0);
  add_case("sltu_x9",      'h120, 'h0020b4b3, 9,  1, 'h00000001, 0, 'h0,   0, 0);
  add_case("sltiu_x10",    'h124, 'h0640b513, 10, 1, 'h00000000, 0, 'h0,   0, 0);
  add_case("add_to_x0",    'h128, 'h00208033, 0,  1, 'h0000007a, 0, 'h0,   0, 0);
  add_case("read_x0",      'h12c, 'h009005b3, 11, 1, 'h00000001, 0, 'h0,   0, 0);
  // Conditional branches on x1 = 123 and x2 = -1
  add_case("beq_taken",    'h130, 'h00b48463, 0,  0, 'h0,        1, 'h138, 0, 0);
  add_case("beq_not",      'h134, 'h00208463, 0,  0, 'h0,        0, 'h0,   0, 0);
  add_case("bne_taken",    'h138, 'hfe2098e3, 0,  0, 'h0,        1, 'h128, 0, 0);
  add_case("bne_not",      'h13c, 'h00b49463, 0,  0, 'h0,        0, 'h0,   0, 0);
  add_case("blt_taken",    'h140, 'h00114463, 0,  0, 'h0,        1, 'h148, 0, 0);
  add_case("bltu_not",     'h144, 'h00116463, 0,  0, 'h0,        0, 'h0,   0, 0);
  add_case("bge_taken",    'h148, 'h0020d463, 0,  0, 'h0,        1, 'h150, 0, 0);
  add_case("bge_not",      'h14c, 'h00115463, 0,  0, 'h0,        0, 'h0,   0, 0);
  add_case("bgeu_taken",   'h150, 'hfe1178e3, 0,  0, 'h0,        1, 'h140, 0, 0);
  add_case("bgeu_not",     'h154, 'h0020f463, 0,  0, 'h0,        0, 'h0,   0, 0);
  add_case("bltu_taken",   'h158, 'h0020e463, 0,  0, 'h0,        1, 'h160, 0, 0);
  add_case("blt_not",      'h15c, 'h0020c463, 0,  0, 'h0,        0, 'h0,   0, 0);
  // Jumps and a use of both link values
  add_case("jal_x12",      'h160, 'h0200066f, 12, 1, 'h00000164, 1, 'h180, 0, 0);
  add_case("jalr_x13",     'h164, 'h030086e7, 13, 1, 'h00000168, 1, 'h0aa, 0, 0);
  add_case("add_links",    'h168, 'h00d60733, 14, 1, 'h000002cc, 0, 'h0,   0, 0);
  // Exceptions followed by reads of the nonzero registers they must not touch
  add_case("ebreak",       'h16c, 'h00100073, 0,  0, 'h0,        0, 'h0,   0, 1);
  add_case("load",         'h170, 'h0000a403, 0,  0, 'h0,        0, 'h0,   1, 0);
  add_case("store",        'h174, 'h0020a223, 0,  0, 'h0,        0, 'h0,   1, 0);
  add_case("bad_word",     'h178, 'hfffff3ff, 0,  0, 'h0,        0, 'h0,   1, 0);
  add_case("read_x7",      'h17c, 'h00938833, 16, 1, 'hedcbb000, 0, 'h0,   0, 0);
  add_case("read_x8",      'h180, 'h00540893, 17, 1, 'h00001184, 0, 'h0,   0, 0);
endfunction

`endif

//--- sim/tb_rv_exec_top.sv
`timescale 1ns/100ps

module tb_rv_exec_top
  import rv_core_pkg::*;
();

  localparam int unsigned SEED       = 32'hec6e;
  localparam int          INIT_STALL = 12;

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [XLEN-1:0]       in_pc;
  logic [XLEN-1:0]       in_inst;
  logic                  res_valid;
  logic                  res_ready;
  logic [XLEN-1:0]       res_pc;
  logic [REG_ADDR_W-1:0] res_rd;
  logic                  res_wena;
  logic [XLEN-1:0]       res_wdata;
  logic                  res_taken;
  logic [XLEN-1:0]       res_target;
  logic                  res_illegal;
  logic                  res_ebreak;

  string                 case_name[$];
  logic [XLEN-1:0]       case_pc[$];
  logic [XLEN-1:0]       case_inst[$];
  logic [REG_ADDR_W-1:0] case_rd[$];
  logic                  case_wena[$];
  logic [XLEN-1:0]       case_wdata[$];
  logic                  case_taken[$];
  logic [XLEN-1:0]       case_target[$];
  logic                  case_illegal[$];
  logic                  case_ebreak[$];

  int timeout_limit = 0;
  int cycle_count = 0;
  bit saw_full;

  rv_exec_top i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .in_valid_i    (in_valid),
    .in_ready_o    (in_ready),
    .in_pc_i       (in_pc),
    .in_inst_i     (in_inst),
    .res_valid_o   (res_valid),
    .res_ready_i   (res_ready),
    .res_pc_o      (res_pc),
    .res_rd_o      (res_rd),
    .res_wena_o    (res_wena),
    .res_wdata_o   (res_wdata),
    .res_taken_o   (res_taken),
    .res_target_o  (res_target),
    .res_illegal_o (res_illegal),
    .res_ebreak_o  (res_ebreak)
  );

  always #50 clk = ~clk;

  function automatic void add_case(input string name, input logic [XLEN-1:0] pc,
                                   input logic [XLEN-1:0] inst,
                                   input logic [REG_ADDR_W-1:0] rd,
                                   input logic wena, input logic [XLEN-1:0] wdata,
                                   input logic taken, input logic [XLEN-1:0] target,
                                   input logic illegal, input logic ebreak);
    case_name.push_back(name);
    case_pc.push_back(pc);
    case_inst.push_back(inst);
    case_rd.push_back(rd);
    case_wena.push_back(wena);
    case_wdata.push_back(wdata);
    case_taken.push_back(taken);
    case_target.push_back(target);
    case_illegal.push_back(illegal);
    case_ebreak.push_back(ebreak);
  endfunction

  `include "tb_cases.svh"

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_field(input int idx, input string field,
                             input logic [XLEN-1:0] exp_val, input logic [XLEN-1:0] act_val);
    assert (act_val === exp_val) else begin
      $display("mismatch %s %s expected %h actual %h", case_name[idx], field, exp_val, act_val);
      stop_run();
    end
  endtask

  task automatic check_record(input int idx);
    check_field(idx, "pc", case_pc[idx], res_pc);
    check_field(idx, "rd", case_rd[idx], res_rd);
    check_field(idx, "wena", case_wena[idx], res_wena);
    check_field(idx, "wdata", case_wdata[idx], res_wdata);
    check_field(idx, "taken", case_taken[idx], res_taken);
    check_field(idx, "target", case_target[idx], res_target);
    check_field(idx, "illegal", case_illegal[idx], res_illegal);
    check_field(idx, "ebreak", case_ebreak[idx], res_ebreak);
  endtask

  // Ready only changes at rising edges, so its value here decides the next transfer
  task automatic drive_inputs();
    bit accepted;
    for (int i = 0; i < case_pc.size(); i++) begin
      in_valid = 1'b1;
      in_pc    = case_pc[i];
      in_inst  = case_inst[i];
      do begin
        accepted = in_ready;
        if (!accepted) begin
          saw_full = 1'b1;
        end
        @(negedge clk);
      end while (!accepted);
    end
    in_valid = 1'b0;
  endtask

  // A stalled record is checked every cycle, so holding is verified too
  task automatic check_results();
    int idx;
    int stall;
    idx   = 0;
    stall = INIT_STALL;
    while (idx < case_pc.size()) begin
      if (stall > 0) begin
        res_ready = 1'b0;
        stall--;
      end else begin
        res_ready = ($urandom % 2) == 1;
      end
      if (res_valid) begin
        check_record(idx);
        if (res_ready) begin
          idx++;
        end
      end
      @(negedge clk);
    end
    res_ready = 1'b1;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      stop_run();
    end
  end

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_pc     = '0;
    in_inst   = '0;
    res_ready = 1'b0;
    saw_full  = 1'b0;
    build_case_table();
    timeout_limit = case_pc.size() * 8 + 50;

    repeat (4) @(negedge clk);
    assert (!res_valid && in_ready) else begin
      $display("after reset the output was valid or the input was not ready");
      stop_run();
    end
    arst_n = 1'b1;

    fork
      drive_inputs();
      check_results();
    join

    repeat (4) @(negedge clk);
    assert (!res_valid) else begin
      $display("an extra retirement record appeared after the last case");
      stop_run();
    end
    assert (saw_full) else begin
      $display("input ready never dropped while the output stream was stalled");
      stop_run();
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
rtl/rv_core_pkg.sv
rtl/inst_fifo.sv
rtl/inst_decode.sv
rtl/regfile.sv
rtl/exec_unit.sv
rtl/rv_exec_top.sv
sim/tb_rv_exec_top.sv
